//--- compile.f
+incdir+verilog
verilog/sram_test_pkg.sv
verilog/scan_cmd_shifter.sv
verilog/sram_1rw1r_model.sv
verilog/sram_access_ctrl.sv
verilog/result_scan_out.sv
verilog/sram_test_top.sv
verification/tb_sram_test.sv

//--- Makefile
# Verilator build and run for the SRAM test chip

VERILATOR ?= verilator
TOP       ?= tb_sram_test
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_STR  ?= STATUS: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_STR)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_sram_test.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_test_settings.svh"

module tb_sram_test
   import sram_test_pkg::*;
;

   localparam int NUM_FIXED   = 18;
   localparam int NUM_TRIPLES = 4;
   localparam int NUM_ROWS    = NUM_FIXED + 3 * NUM_TRIPLES;
   localparam int SEED        = 6;
   // One scan round plus the load handshake fits well inside 80 cycles
   localparam int CYCLE_LIMIT = (NUM_ROWS + 1) * 80 + 5 + 100;

   typedef struct {
      sram_op_e                      op;
      logic                          sel;
      logic [`SRAM_ADDR_SIZE-1:0]    a0;
      logic [`SRAM_ADDR_SIZE-1:0]    a1;
      logic [`SRAM_WMASK_SIZE-1:0]   mask;
      logic [`SRAM_DATA_SIZE-1:0]    data;
      int                            hold;
      logic [`SCAN_RESULT_LEN-1:0]   exp;
   } row_t;

   logic clk;
   logic resetn;
   logic scan_i;
   logic scan_data_i;
   logic load_i;
   logic scan_data_o;
   logic busy_o;

   row_t rows [NUM_ROWS];
   // Reference contents per macro
   // Macro 0 uses only the first 256 entries
   logic [`SRAM_DATA_SIZE-1:0] ref_mem [2][1 << `SRAM_ADDR_SIZE];
   int cycle_cnt = 0;

   sram_test_top i_dut (
      .clk         (clk),
      .resetn      (resetn),
      .scan_i      (scan_i),
      .scan_data_i (scan_data_i),
      .load_i      (load_i),
      .scan_data_o (scan_data_o),
      .busy_o      (busy_o)
   );

   initial begin
      clk = 1'b0;
   end

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("STATUS: FAIL");
         $fatal(1, "Timeout");
      end
   end

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0d ns: %s, got %h expected %h", $time, what, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "Mismatch");
      end
   endtask

   task automatic set_row(input int i, input sram_op_e op, input logic sel,
                          input logic [9:0] a0, input logic [9:0] a1,
                          input logic [3:0] mask, input logic [31:0] data, input int hold);
      rows[i].op   = op;
      rows[i].sel  = sel;
      rows[i].a0   = a0;
      rows[i].a1   = a1;
      rows[i].mask = mask;
      rows[i].data = data;
      rows[i].hold = hold;
      rows[i].exp  = '0;
   endtask

   function automatic int ref_index(input logic sel, input logic [9:0] a);
      return sel ? int'(a) : int'(a) % (1 << `SRAM_SMALL_ADDR_BITS);
   endfunction

   // Walk the table in order and fill in the expected results
   task automatic compute_expected();
      int i0;
      int i1;
      logic [31:0] rd0;
      logic [31:0] old1;
      for (int r = 0; r < NUM_ROWS; r++) begin
         i0   = ref_index(rows[r].sel, rows[r].a0);
         i1   = ref_index(rows[r].sel, rows[r].a1);
         rd0  = ref_mem[rows[r].sel][i0];
         old1 = ref_mem[rows[r].sel][i1];
         case (rows[r].op)
            OP_READ:       rows[r].exp = {rd0, old1};
            OP_WRITE_READ: rows[r].exp = {32'h0, old1};
            default:       rows[r].exp = '0;
         endcase
         if (rows[r].op == OP_WRITE || rows[r].op == OP_WRITE_READ) begin
            for (int b = 0; b < `SRAM_WMASK_SIZE; b++) begin
               if (rows[r].mask[b]) begin
                  ref_mem[rows[r].sel][i0][b*8 +: 8] = rows[r].data[b*8 +: 8];
               end
            end
         end
      end
   endtask

   // 5 pad bits then the command MSB first while the old result comes out
   task automatic scan_round(input logic [58:0] cmd, output logic [63:0] got);
      logic [63:0] pkt;
      pkt = {5'b0, cmd};
      for (int i = 0; i < 64; i++) begin
         @(posedge clk);
         scan_i      <= 1'b1;
         scan_data_i <= pkt[63-i];
         @(negedge clk);
         got[63-i] = scan_data_o;
      end
      @(posedge clk);
      scan_i      <= 1'b0;
      scan_data_i <= 1'b0;
   endtask

   // Hold load_i for hold edges and count the busy cycles
   task automatic pulse_load(input int hold);
      int edges;
      int high_cnt;
      bit seen;
      bit done;
      edges    = 0;
      high_cnt = 0;
      seen     = 1'b0;
      done     = 1'b0;
      @(posedge clk);
      load_i <= 1'b1;
      while (!done) begin
         @(negedge clk);
         if (busy_o) begin
            high_cnt++;
            seen = 1'b1;
         end else if (seen) begin
            done = 1'b1;
         end
         if (!done) begin
            @(posedge clk);
            edges++;
            if (edges >= hold) begin
               load_i <= 1'b0;
            end
         end
      end
      check(64'(high_cnt), 64'd2, "busy_o cycles after a load");
      if (hold > 1) begin
         repeat (3) begin
            @(negedge clk);
            check(64'(busy_o), 64'd0, "busy_o after a load held while busy");
         end
      end
   endtask

   initial begin
      logic [63:0] got;
      logic [31:0] addr_seed;
      scan_i      <= 1'b0;
      scan_data_i <= 1'b0;
      load_i      <= 1'b0;
      resetn      <= 1'b0;
      void'($urandom(SEED));

      // Fixed rows where sel 0 is the 256-word macro
      set_row(0,  OP_WRITE,      1'b0, 10'h010, 10'h000, 4'hF, 32'h11223344, 1);
      set_row(1,  OP_WRITE,      1'b0, 10'h020, 10'h000, 4'hF, 32'hA5A5A5A5, 1);
      set_row(2,  OP_READ,       1'b0, 10'h010, 10'h020, 4'h0, 32'h0,        1);
      set_row(3,  OP_WRITE,      1'b0, 10'h010, 10'h000, 4'h5, 32'hFFEEDDCC, 1);
      set_row(4,  OP_WRITE,      1'b1, 10'h010, 10'h000, 4'hF, 32'hCAFEF00D, 1);
      set_row(5,  OP_WRITE,      1'b1, 10'h110, 10'h000, 4'hF, 32'h0BADBEEF, 1);
      set_row(6,  OP_READ,       1'b1, 10'h010, 10'h110, 4'h0, 32'h0,        1);
      set_row(7,  OP_READ,       1'b0, 10'h010, 10'h020, 4'h0, 32'h0,        1);
      // Upper address bits alias on macro 0 only
      set_row(8,  OP_WRITE,      1'b0, 10'h310, 10'h000, 4'hF, 32'h55AA55AA, 1);
      set_row(9,  OP_READ,       1'b0, 10'h010, 10'h210, 4'h0, 32'h0,        1);
      set_row(10, OP_READ,       1'b1, 10'h110, 10'h010, 4'h0, 32'h0,        1);
      set_row(11, OP_WRITE_READ, 1'b1, 10'h010, 10'h010, 4'hF, 32'h12345678, 1);
      set_row(12, OP_READ,       1'b1, 10'h010, 10'h110, 4'h0, 32'h0,        1);
      set_row(13, OP_WRITE_READ, 1'b0, 10'h020, 10'h020, 4'h3, 32'h0000BEEF, 1);
      set_row(14, OP_NOP,        1'b0, 10'h020, 10'h020, 4'hF, 32'hFFFFFFFF, 3);
      set_row(15, OP_WRITE,      1'b1, 10'h3FF, 10'h000, 4'hF, 32'hDEADBEEF, 3);
      set_row(16, OP_READ,       1'b0, 10'h020, 10'h110, 4'h0, 32'h0,        1);
      set_row(17, OP_READ,       1'b1, 10'h3FF, 10'h3FF, 4'h0, 32'h0,        1);

      // Random write, write-read and read on one address per triple
      for (int t = 0; t < NUM_TRIPLES; t++) begin
         addr_seed = $urandom;
         set_row(NUM_FIXED + 3*t, OP_WRITE, addr_seed[10], addr_seed[9:0], addr_seed[9:0],
                 4'hF, $urandom, 1);
         set_row(NUM_FIXED + 3*t + 1, OP_WRITE_READ, addr_seed[10], addr_seed[9:0],
                 addr_seed[9:0], 4'($urandom), $urandom, 1);
         set_row(NUM_FIXED + 3*t + 2, OP_READ, addr_seed[10], addr_seed[9:0],
                 addr_seed[9:0], 4'h0, 32'h0, 1);
      end
      compute_expected();

      repeat (5) @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      check(64'(scan_data_o), 64'd0, "scan_data_o after reset");
      check(64'(busy_o), 64'd0, "busy_o after reset");

      // Round r returns the result of row r-1
      // The last round is a dummy
      for (int r = 0; r <= NUM_ROWS; r++) begin
         if (r < NUM_ROWS) begin
            scan_round({rows[r].op, rows[r].sel, rows[r].a0, rows[r].a1,
                        rows[r].mask, rows[r].data}, got);
         end else begin
            scan_round(59'd0, got);
         end
         if (r == 0) begin
            check(got, 64'd0, "first scan-out after reset");
         end else begin
            check(got, rows[r-1].exp, $sformatf("result of row %0d", r - 1));
         end
         if (r < NUM_ROWS) begin
            pulse_load(rows[r].hold);
         end
      end

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/sram_test_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_test_settings.svh"

module sram_test_top
   import sram_test_pkg::*;
(
   input  wire    clk,
   input  wire    resetn,
   input  wire    scan_i,
   input  wire    scan_data_i,
   input  wire    load_i,
   output logic   scan_data_o,
   output logic   busy_o
);

   sram_op_e                     cmd_op;
   logic                         cmd_sel;
   logic [`SRAM_ADDR_SIZE-1:0]   cmd_addr0;
   logic [`SRAM_ADDR_SIZE-1:0]   cmd_addr1;
   logic [`SRAM_WMASK_SIZE-1:0]  cmd_wmask;
   logic [`SRAM_DATA_SIZE-1:0]   cmd_data;

   // Shared macro pins, one select bit per macro
   logic [`SRAM_MACRO_COUNT-1:0] csb0;
   logic [`SRAM_MACRO_COUNT-1:0] csb1;
   logic                         web0;
   logic [`SRAM_WMASK_SIZE-1:0]  wmask0;
   logic [`SRAM_ADDR_SIZE-1:0]   addr0;
   logic [`SRAM_ADDR_SIZE-1:0]   addr1;
   logic [`SRAM_DATA_SIZE-1:0]   din0;

   logic [`SRAM_DATA_SIZE-1:0]   m0_dout0;
   logic [`SRAM_DATA_SIZE-1:0]   m0_dout1;
   logic [`SRAM_DATA_SIZE-1:0]   m1_dout0;
   logic [`SRAM_DATA_SIZE-1:0]   m1_dout1;

   logic                         result_valid;
   logic [`SCAN_RESULT_LEN-1:0]  result;

   scan_cmd_shifter u_scan_in (
      .clk         (clk),
      .resetn      (resetn),
      .scan_i      (scan_i),
      .scan_data_i (scan_data_i),
      .cmd_op_o    (cmd_op),
      .cmd_sel_o   (cmd_sel),
      .cmd_addr0_o (cmd_addr0),
      .cmd_addr1_o (cmd_addr1),
      .cmd_wmask_o (cmd_wmask),
      .cmd_data_o  (cmd_data)
   );

   sram_access_ctrl u_access (
      .clk            (clk),
      .resetn         (resetn),
      .load_i         (load_i),
      .cmd_op_i       (cmd_op),
      .cmd_sel_i      (cmd_sel),
      .cmd_addr0_i    (cmd_addr0),
      .cmd_addr1_i    (cmd_addr1),
      .cmd_wmask_i    (cmd_wmask),
      .cmd_data_i     (cmd_data),
      .m0_dout0_i     (m0_dout0),
      .m0_dout1_i     (m0_dout1),
      .m1_dout0_i     (m1_dout0),
      .m1_dout1_i     (m1_dout1),
      .busy_o         (busy_o),
      .csb0_o         (csb0),
      .csb1_o         (csb1),
      .web0_o         (web0),
      .wmask0_o       (wmask0),
      .addr0_o        (addr0),
      .addr1_o        (addr1),
      .din0_o         (din0),
      .result_valid_o (result_valid),
      .result_o       (result)
   );

   // Macro 0 only sees the low address bits, so upper addresses alias
   sram_1rw1r_model #(
      .ADDR_BITS (`SRAM_SMALL_ADDR_BITS)
   ) u_sram_small (
      .clk      (clk),
      .csb0_i   (csb0[0]),
      .web0_i   (web0),
      .wmask0_i (wmask0),
      .addr0_i  (addr0[`SRAM_SMALL_ADDR_BITS-1:0]),
      .din0_i   (din0),
      .dout0_o  (m0_dout0),
      .csb1_i   (csb1[0]),
      .addr1_i  (addr1[`SRAM_SMALL_ADDR_BITS-1:0]),
      .dout1_o  (m0_dout1)
   );

   sram_1rw1r_model #(
      .ADDR_BITS (`SRAM_ADDR_SIZE)
   ) u_sram_large (
      .clk      (clk),
      .csb0_i   (csb0[1]),
      .web0_i   (web0),
      .wmask0_i (wmask0),
      .addr0_i  (addr0),
      .din0_i   (din0),
      .dout0_o  (m1_dout0),
      .csb1_i   (csb1[1]),
      .addr1_i  (addr1),
      .dout1_o  (m1_dout1)
   );

   result_scan_out u_scan_out (
      .clk            (clk),
      .resetn         (resetn),
      .scan_i         (scan_i),
      .result_valid_i (result_valid),
      .result_i       (result),
      .scan_data_o    (scan_data_o)
   );

endmodule

`default_nettype wire

//--- verilog/result_scan_out.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_test_settings.svh"

module result_scan_out (
   input  wire                          clk,
   input  wire                          resetn,
   input  wire                          scan_i,
   input  wire                          result_valid_i,
   input  wire [`SCAN_RESULT_LEN-1:0]   result_i,
   output logic                         scan_data_o
);

   logic [`SCAN_RESULT_LEN-1:0] result_q;

   // Parallel load wins over a shift in the same cycle
   always_ff @(posedge clk) begin
      if (!resetn) begin
         result_q <= '0;
      end else if (result_valid_i) begin
         result_q <= result_i;
      end else if (scan_i) begin
         result_q <= {result_q[`SCAN_RESULT_LEN-2:0], 1'b0};
      end
   end

   // Port 0 word leaves first
   assign scan_data_o = result_q[`SCAN_RESULT_LEN-1];

endmodule

`default_nettype wire

//--- verilog/sram_access_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_test_settings.svh"

module sram_access_ctrl
   import sram_test_pkg::*;
(
   input  wire                            clk,
   input  wire                            resetn,
   input  wire                            load_i,
   input  wire sram_op_e                  cmd_op_i,
   input  wire                            cmd_sel_i,
   input  wire [`SRAM_ADDR_SIZE-1:0]      cmd_addr0_i,
   input  wire [`SRAM_ADDR_SIZE-1:0]      cmd_addr1_i,
   input  wire [`SRAM_WMASK_SIZE-1:0]     cmd_wmask_i,
   input  wire [`SRAM_DATA_SIZE-1:0]      cmd_data_i,
   input  wire [`SRAM_DATA_SIZE-1:0]      m0_dout0_i,
   input  wire [`SRAM_DATA_SIZE-1:0]      m0_dout1_i,
   input  wire [`SRAM_DATA_SIZE-1:0]      m1_dout0_i,
   input  wire [`SRAM_DATA_SIZE-1:0]      m1_dout1_i,
   output logic                           busy_o,
   output logic [`SRAM_MACRO_COUNT-1:0]   csb0_o,
   output logic [`SRAM_MACRO_COUNT-1:0]   csb1_o,
   output logic                           web0_o,
   output logic [`SRAM_WMASK_SIZE-1:0]    wmask0_o,
   output logic [`SRAM_ADDR_SIZE-1:0]     addr0_o,
   output logic [`SRAM_ADDR_SIZE-1:0]     addr1_o,
   output logic [`SRAM_DATA_SIZE-1:0]     din0_o,
   output logic                           result_valid_o,
   output logic [`SCAN_RESULT_LEN-1:0]    result_o
);

   access_state_e state_q;
   sram_op_e      op_q;
   logic          sel_q;
   logic [`SRAM_ADDR_SIZE-1:0]  addr0_q;
   logic [`SRAM_ADDR_SIZE-1:0]  addr1_q;
   logic [`SRAM_WMASK_SIZE-1:0] wmask_q;
   logic [`SRAM_DATA_SIZE-1:0]  data_q;
   logic port0_en;
   logic port0_wr;
   logic port1_en;
   logic [`SRAM_DATA_SIZE-1:0]  word0;
   logic [`SRAM_DATA_SIZE-1:0]  word1;
   logic start;

   // Loads arriving while busy are dropped
   assign start = (state_q == ST_IDLE) && load_i;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= ST_IDLE;
         op_q    <= OP_NOP;
         sel_q   <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (load_i) begin
                  state_q <= ST_ACCESS;
                  op_q    <= cmd_op_i;
                  sel_q   <= cmd_sel_i;
               end
            end
            ST_ACCESS: state_q <= ST_WAIT;
            default:   state_q <= ST_IDLE;
         endcase
      end
   end

   // Command payload
   always_ff @(posedge clk) begin
      if (start) begin
         addr0_q <= cmd_addr0_i;
         addr1_q <= cmd_addr1_i;
         wmask_q <= cmd_wmask_i;
         data_q  <= cmd_data_i;
      end
   end

   // Which ports the opcode touches
   assign port0_en = (op_q != OP_NOP);
   assign port0_wr = (op_q == OP_WRITE) || (op_q == OP_WRITE_READ);
   assign port1_en = (op_q == OP_READ) || (op_q == OP_WRITE_READ);

   // Active-low selects, only the chosen macro and only in ST_ACCESS
   always_comb begin
      csb0_o = '1;
      csb1_o = '1;
      if (state_q == ST_ACCESS) begin
         if (port0_en) begin
            csb0_o[sel_q] = 1'b0;
         end
         if (port1_en) begin
            csb1_o[sel_q] = 1'b0;
         end
      end
   end

   assign web0_o   = !((state_q == ST_ACCESS) && port0_wr);
   assign wmask0_o = wmask_q;
   assign addr0_o  = addr0_q;
   assign addr1_o  = addr1_q;
   assign din0_o   = data_q;

   assign busy_o = (state_q != ST_IDLE);

   // Macro outputs are valid during ST_WAIT
   assign word0 = sel_q ? m1_dout0_i : m0_dout0_i;
   assign word1 = sel_q ? m1_dout1_i : m0_dout1_i;

   assign result_valid_o = (state_q == ST_WAIT);
   assign result_o = {(op_q == OP_READ) ? word0 : '0,
                      port1_en ? word1 : '0};

endmodule

`default_nettype wire

//--- verilog/sram_1rw1r_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_test_settings.svh"

module sram_1rw1r_model #(
   parameter int ADDR_BITS = `SRAM_ADDR_SIZE
) (
   input  wire                          clk,
   // Port 0, read-write
   input  wire                          csb0_i,
   input  wire                          web0_i,
   input  wire [`SRAM_WMASK_SIZE-1:0]   wmask0_i,
   input  wire [ADDR_BITS-1:0]          addr0_i,
   input  wire [`SRAM_DATA_SIZE-1:0]    din0_i,
   output logic [`SRAM_DATA_SIZE-1:0]   dout0_o,
   // Port 1, read only
   input  wire                          csb1_i,
   input  wire [ADDR_BITS-1:0]          addr1_i,
   output logic [`SRAM_DATA_SIZE-1:0]   dout1_o
);

   localparam int DEPTH = 1 << ADDR_BITS;

   logic [`SRAM_DATA_SIZE-1:0] mem [DEPTH];

   // Port 0 write merges only the enabled bytes
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int b = 0; b < `SRAM_WMASK_SIZE; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i];
         end
      end
   end

   // Port 1 samples before any same-edge write lands
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[addr1_i];
      end
   end

endmodule

`default_nettype wire

//--- verilog/scan_cmd_shifter.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_test_settings.svh"

module scan_cmd_shifter
   import sram_test_pkg::*;
(
   input  wire                          clk,
   input  wire                          resetn,
   input  wire                          scan_i,
   input  wire                          scan_data_i,
   output sram_op_e                     cmd_op_o,
   output logic                         cmd_sel_o,
   output logic [`SRAM_ADDR_SIZE-1:0]   cmd_addr0_o,
   output logic [`SRAM_ADDR_SIZE-1:0]   cmd_addr1_o,
   output logic [`SRAM_WMASK_SIZE-1:0]  cmd_wmask_o,
   output logic [`SRAM_DATA_SIZE-1:0]   cmd_data_o
);

   // Field positions, data sits at the bottom of the packet
   localparam int WMASK_LSB = `SRAM_DATA_SIZE;
   localparam int ADDR1_LSB = WMASK_LSB + `SRAM_WMASK_SIZE;
   localparam int ADDR0_LSB = ADDR1_LSB + `SRAM_ADDR_SIZE;
   localparam int SEL_BIT   = ADDR0_LSB + `SRAM_ADDR_SIZE;
   localparam int OP_LSB    = SEL_BIT + 1;

   logic [`SCAN_CMD_LEN-1:0] cmd_q;

   // Serial data enters at bit 0 and moves up
   always_ff @(posedge clk) begin
      if (!resetn) begin
         cmd_q <= '0;
      end else if (scan_i) begin
         cmd_q <= {cmd_q[`SCAN_CMD_LEN-2:0], scan_data_i};
      end
   end

   // Opcode occupies the top two bits
   assign cmd_op_o    = sram_op_e'(cmd_q[OP_LSB +: 2]);
   assign cmd_sel_o   = cmd_q[SEL_BIT];
   assign cmd_addr0_o = cmd_q[ADDR0_LSB +: `SRAM_ADDR_SIZE];
   assign cmd_addr1_o = cmd_q[ADDR1_LSB +: `SRAM_ADDR_SIZE];
   assign cmd_wmask_o = cmd_q[WMASK_LSB +: `SRAM_WMASK_SIZE];
   assign cmd_data_o  = cmd_q[`SRAM_DATA_SIZE-1:0];

endmodule

`default_nettype wire

//--- verilog/sram_test_pkg.sv
`default_nettype none

package sram_test_pkg;

   // Command opcodes as shifted in by the tester
   typedef enum logic [1:0] {
      OP_NOP        = 2'b00,
      OP_WRITE      = 2'b01,
      OP_READ       = 2'b10,
      OP_WRITE_READ = 2'b11
   } sram_op_e;

   // Sequencer states
   // ST_ACCESS drives the macro pins for one cycle
   // ST_WAIT sees the registered macro outputs
   typedef enum logic [1:0] {
      ST_IDLE   = 2'b00,
      ST_ACCESS = 2'b01,
      ST_WAIT   = 2'b10
   } access_state_e;

endpackage

`default_nettype wire

//--- verilog/sram_test_settings.svh
`ifndef SRAM_TEST_SETTINGS_SVH
`define SRAM_TEST_SETTINGS_SVH

// Data width of both macro ports
`define SRAM_DATA_SIZE 32

// Address field width carried in the command
`define SRAM_ADDR_SIZE 10

// One write mask bit per byte
`define SRAM_WMASK_SIZE 4

// Macro 0 is 256 words deep
`define SRAM_SMALL_ADDR_BITS 8

`define SRAM_MACRO_COUNT 2

// Opcode, select, two addresses, mask and data
`define SCAN_CMD_LEN 59

// Port 0 word followed by port 1 word
`define SCAN_RESULT_LEN 64

`endif
